/* bench/wb_com_trace.txt */
# columns: we addr wdata exp_rdata exp_err, all hex
# we=1 is a write; exp_err=1 expects err instead of ack; writes return zero data
1 00000000 a0a00001 00000000 0
0 00000000 00000000 a0a00001 0
1 00000005 b5b50005 00000000 0
0 00000005 00000000 b5b50005 0
0 00000009 00000000 00000000 1
1 00000001 11111111 00000000 0
1 00000004 44444444 00000000 0
0 00000001 00000000 11111111 0
0 00000004 00000000 44444444 0
0 00000000 00000000 a0a00001 0
0 00000006 00000000 5a000006 0
1 00000007 77777777 00000000 1
0 00000007 00000000 00000000 1
0 00000005 00000000 b5b50005 0
1 00000002 22222222 00000000 0
1 00000003 33333333 00000000 0
0 00000002 00000000 22222222 0
0 00000003 00000000 33333333 0
0 00000000 00000000 a0a00001 0
0 00000001 00000000 11111111 0
0 00000002 00000000 22222222 0

/* flist.f */
+incdir+include
src/wb_com_pkg.sv
src/wb_com_fifo.sv
src/wb_com_master.sv
src/wb_com_slave.sv
src/wb_commutator.sv
bench/tb_wb_commutator.sv

/* Makefile */
TOP := tb_wb_commutator

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -o $(TOP)

# verdict comes from the pass line in the simulator output
run: compile
	@out=$$(./obj_dir/$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q '^Result: PASSED$$'

clean:
	rm -rf obj_dir

/* bench/tb_wb_commutator.sv */
// needs bench/wb_com_trace.txt relative to the run directory; slave models hold 4 words each
`timescale 1ns/1ps
`include "wb_com_params.svh"

module tb_wb_commutator;

  logic                  clk;
  logic                  rst;
  logic [`WB_COM_AW-1:0] m_addr_i;
  logic [`WB_COM_DW-1:0] m_dat_i;
  logic [`WB_COM_SW-1:0] m_sel_i;
  logic                  m_cyc_i;
  logic                  m_stb_i;
  logic                  m_we_i;
  logic [`WB_COM_DW-1:0] m_dat_o;
  logic                  m_stall_o;
  logic                  m_ack_o;
  logic                  m_err_o;
  logic [`WB_COM_AW-1:0] s0_adr_o;
  logic [`WB_COM_DW-1:0] s0_dat_o;
  logic [`WB_COM_SW-1:0] s0_sel_o;
  logic                  s0_we_o;
  logic                  s0_cyc_o;
  logic                  s0_stb_o;
  logic [`WB_COM_DW-1:0] s0_dat_i;
  logic                  s0_ack_i;
  logic                  s0_err_i;
  logic [`WB_COM_AW-1:0] s1_adr_o;
  logic [`WB_COM_DW-1:0] s1_dat_o;
  logic [`WB_COM_SW-1:0] s1_sel_o;
  logic                  s1_we_o;
  logic                  s1_cyc_o;
  logic                  s1_stb_o;
  logic [`WB_COM_DW-1:0] s1_dat_i;
  logic                  s1_ack_i;
  logic                  s1_err_i;

  // trace contents and expected responses in request order
  logic                  tr_we [$];
  logic [31:0]           tr_adr [$];
  logic [31:0]           tr_wdat [$];
  logic [31:0]           exp_dat_q [$];
  logic                  exp_err_q [$];
  int                    n_trans;
  int                    mapped_cnt;
  int                    rsp_cnt;
  int                    xfer_cnt;
  int                    cycle_cnt;
  int                    cycle_limit;
  logic                  stall_seen;
  logic                  taken;
  int                    idx;
  // slave model state
  logic [31:0]           mem [2][4];
  logic                  busy [2];
  int unsigned           wait_cnt [2];
  int unsigned           lcg_state;

  wb_commutator UUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // helpers
  // --------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  task automatic read_trace();
    string       line;
    int          fd;
    int          n;
    logic [31:0] f_we;
    logic [31:0] f_adr;
    logic [31:0] f_wd;
    logic [31:0] f_rd;
    logic [31:0] f_er;
    fd = $fopen("bench/wb_com_trace.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the trace file bench/wb_com_trace.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // skip blank and comment lines
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h", f_we, f_adr, f_wd, f_rd, f_er);
      if (n != 5) begin
        abort_run($sformatf("trace line is malformed: %s", line));
      end
      tr_we.push_back(f_we[0]);
      tr_adr.push_back(f_adr);
      tr_wdat.push_back(f_wd);
      exp_dat_q.push_back(f_rd);
      exp_err_q.push_back(f_er[0]);
      if (f_adr <= `WB_COM_S0_HI || (f_adr >= `WB_COM_S1_LO && f_adr <= `WB_COM_S1_HI)) begin
        mapped_cnt++;
      end
    end
    $fclose(fd);
    n_trans = tr_adr.size();
  endtask

  // one clock of a slave model; word 7 on slave 1 always answers err
  task automatic serve_slave(input int s, input logic cyc, input logic stb, input logic we,
                             input logic [31:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel, output logic ack, output logic err,
                             output logic [31:0] rdat);
    ack  = 1'b0;
    err  = 1'b0;
    rdat = '0;
    if (cyc && stb) begin
      if (!busy[s]) begin
        busy[s]     = 1'b1;
        wait_cnt[s] = lcg_next() % 4;
      end
      if (wait_cnt[s] == 0) begin
        busy[s] = 1'b0;
        xfer_cnt++;
        if (s == 1 && adr == 32'd7) begin
          err = 1'b1;
        end else if (we) begin
          for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
              mem[s][adr[1:0]][8*b +: 8] = wdat[8*b +: 8];
            end
          end
        end else begin
          rdat = mem[s][adr[1:0]];
        end
        ack = !err;
      end else begin
        wait_cnt[s]--;
      end
    end
  endtask

  // --------------------
  // slave models
  // --------------------
  always @(posedge clk) begin
    #2;
    serve_slave(0, s0_cyc_o, s0_stb_o, s0_we_o, s0_adr_o, s0_dat_o, s0_sel_o,
                s0_ack_i, s0_err_i, s0_dat_i);
    serve_slave(1, s1_cyc_o, s1_stb_o, s1_we_o, s1_adr_o, s1_dat_o, s1_sel_o,
                s1_ack_i, s1_err_i, s1_dat_i);
  end

  // responses are compared mid-cycle where ack and err are settled
  always @(negedge clk) begin
    logic [31:0] exp_dat;
    logic        exp_err;
    if (!rst && (m_ack_o || m_err_o)) begin
      if (exp_err_q.size() == 0) begin
        abort_run("the DUT returned more responses than there are requests");
      end
      exp_dat = exp_dat_q.pop_front();
      exp_err = exp_err_q.pop_front();
      check_value("m_err_o", m_err_o, exp_err);
      check_value("m_ack_o", m_ack_o, !exp_err);
      if (m_ack_o) begin
        check_value("m_dat_o", m_dat_o, exp_dat);
      end
      rsp_cnt++;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
      abort_run("timeout: not every request got its response in time");
    end
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    rst         = 1'b1;
    m_addr_i    = '0;
    m_dat_i     = '0;
    m_sel_i     = '1;
    m_cyc_i     = 1'b0;
    m_stb_i     = 1'b0;
    m_we_i      = 1'b0;
    s0_dat_i    = '0;
    s0_ack_i    = 1'b0;
    s0_err_i    = 1'b0;
    s1_dat_i    = '0;
    s1_ack_i    = 1'b0;
    s1_err_i    = 1'b0;
    lcg_state   = 6;
    stall_seen  = 1'b0;
    rsp_cnt     = 0;
    xfer_cnt    = 0;
    cycle_cnt   = 0;
    mapped_cnt  = 0;
    cycle_limit = 0;
    for (int s = 0; s < 2; s++) begin
      busy[s]     = 1'b0;
      wait_cnt[s] = 0;
      for (int i = 0; i < 4; i++) begin
        mem[s][i] = 32'h5a00_0000 | (s * 4 + i);
      end
    end
    read_trace();
    cycle_limit = 40 * n_trans;

    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    check_value("m_ack_o after reset", m_ack_o, 1'b0);
    check_value("m_err_o after reset", m_err_o, 1'b0);
    check_value("m_stall_o after reset", m_stall_o, 1'b0);

    // back to back requests with a stalled one held until taken
    @(posedge clk);
    #2;
    idx = 0;
    while (idx < n_trans) begin
      m_cyc_i  = 1'b1;
      m_stb_i  = 1'b1;
      m_we_i   = tr_we[idx];
      m_addr_i = tr_adr[idx];
      m_dat_i  = tr_wdat[idx];
      @(negedge clk);
      taken = !m_stall_o;
      if (m_stall_o) begin
        stall_seen = 1'b1;
      end
      @(posedge clk);
      #2;
      if (taken) begin
        idx++;
      end
    end
    m_stb_i = 1'b0;
    wait (rsp_cnt == n_trans);
    @(posedge clk);
    #2;
    m_cyc_i = 1'b0;

    check_value("slave transfer count", xfer_cnt, mapped_cnt);
    check_value("m_stall_o seen", stall_seen, 1'b1);
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* src/wb_commutator.sv */
// one pipelined master to two classic slaves through FIFOs; no arbitration or clock crossing
`timescale 1ns/1ps
`include "wb_com_params.svh"

module wb_commutator
  import wb_com_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  // master bus
  input  logic [`WB_COM_AW-1:0] m_addr_i,
  input  logic [`WB_COM_DW-1:0] m_dat_i,
  input  logic [`WB_COM_SW-1:0] m_sel_i,
  input  logic                  m_cyc_i,
  input  logic                  m_stb_i,
  input  logic                  m_we_i,
  output logic [`WB_COM_DW-1:0] m_dat_o,
  output logic                  m_stall_o,
  output logic                  m_ack_o,
  output logic                  m_err_o,
  // slave 0 bus
  output logic [`WB_COM_AW-1:0] s0_adr_o,
  output logic [`WB_COM_DW-1:0] s0_dat_o,
  output logic [`WB_COM_SW-1:0] s0_sel_o,
  output logic                  s0_we_o,
  output logic                  s0_cyc_o,
  output logic                  s0_stb_o,
  input  logic [`WB_COM_DW-1:0] s0_dat_i,
  input  logic                  s0_ack_i,
  input  logic                  s0_err_i,
  // slave 1 bus
  output logic [`WB_COM_AW-1:0] s1_adr_o,
  output logic [`WB_COM_DW-1:0] s1_dat_o,
  output logic [`WB_COM_SW-1:0] s1_sel_o,
  output logic                  s1_we_o,
  output logic                  s1_cyc_o,
  output logic                  s1_stb_o,
  input  logic [`WB_COM_DW-1:0] s1_dat_i,
  input  logic                  s1_ack_i,
  input  logic                  s1_err_i
);

  // --------------------
  // request paths
  // --------------------
  wb_req_hdr_t           s0_hdr;
  wb_req_hdr_t           s1_hdr;
  logic                  s0_hdr_rden;
  logic                  s1_hdr_rden;
  logic                  s0_hdr_empty;
  logic                  s1_hdr_empty;
  logic [`WB_COM_DW-1:0] s0_wdat;
  logic [`WB_COM_DW-1:0] s1_wdat;
  logic                  s0_wdat_rden;
  logic                  s1_wdat_rden;

  // --------------------
  // response paths
  // --------------------
  wb_rsp_t               s0_rsp_in;
  wb_rsp_t               s1_rsp_in;
  logic                  s0_rsp_wren;
  logic                  s1_rsp_wren;
  logic                  s0_rsp_full;
  logic                  s1_rsp_full;
  wb_rsp_t               s0_rsp;
  wb_rsp_t               s1_rsp;
  logic                  s0_rsp_empty;
  logic                  s1_rsp_empty;
  logic                  s0_rsp_rden;
  logic                  s1_rsp_rden;

  wb_com_master u_master (
    .clk            (clk),
    .rst            (rst),
    .m_addr_i       (m_addr_i),
    .m_dat_i        (m_dat_i),
    .m_sel_i        (m_sel_i),
    .m_cyc_i        (m_cyc_i),
    .m_stb_i        (m_stb_i),
    .m_we_i         (m_we_i),
    .m_dat_o        (m_dat_o),
    .m_stall_o      (m_stall_o),
    .m_ack_o        (m_ack_o),
    .m_err_o        (m_err_o),
    .s0_hdr_o       (s0_hdr),
    .s0_hdr_rden_i  (s0_hdr_rden),
    .s0_hdr_empty_o (s0_hdr_empty),
    .s0_wdat_o      (s0_wdat),
    .s0_wdat_rden_i (s0_wdat_rden),
    .s0_rsp_i       (s0_rsp),
    .s0_rsp_empty_i (s0_rsp_empty),
    .s0_rsp_rden_o  (s0_rsp_rden),
    .s1_hdr_o       (s1_hdr),
    .s1_hdr_rden_i  (s1_hdr_rden),
    .s1_hdr_empty_o (s1_hdr_empty),
    .s1_wdat_o      (s1_wdat),
    .s1_wdat_rden_i (s1_wdat_rden),
    .s1_rsp_i       (s1_rsp),
    .s1_rsp_empty_i (s1_rsp_empty),
    .s1_rsp_rden_o  (s1_rsp_rden)
  );

  wb_com_fifo #(.WIDTH($bits(wb_rsp_t)), .ASIZE(`WB_COM_FIFO_ASIZE)) u_s0_rsp_fifo (
    .clk       (clk),
    .rst       (rst),
    .wr_en_i   (s0_rsp_wren),
    .wr_data_i (s0_rsp_in),
    .rd_en_i   (s0_rsp_rden),
    .rd_data_o (s0_rsp),
    .full_o    (s0_rsp_full),
    .empty_o   (s0_rsp_empty)
  );

  wb_com_fifo #(.WIDTH($bits(wb_rsp_t)), .ASIZE(`WB_COM_FIFO_ASIZE)) u_s1_rsp_fifo (
    .clk       (clk),
    .rst       (rst),
    .wr_en_i   (s1_rsp_wren),
    .wr_data_i (s1_rsp_in),
    .rd_en_i   (s1_rsp_rden),
    .rd_data_o (s1_rsp),
    .full_o    (s1_rsp_full),
    .empty_o   (s1_rsp_empty)
  );

  wb_com_slave u_slave0 (
    .clk         (clk),
    .rst         (rst),
    .hdr_i       (s0_hdr),
    .hdr_empty_i (s0_hdr_empty),
    .wdat_i      (s0_wdat),
    .hdr_rden_o  (s0_hdr_rden),
    .wdat_rden_o (s0_wdat_rden),
    .rsp_o       (s0_rsp_in),
    .rsp_wren_o  (s0_rsp_wren),
    .rsp_full_i  (s0_rsp_full),
    .adr_o       (s0_adr_o),
    .dat_o       (s0_dat_o),
    .sel_o       (s0_sel_o),
    .we_o        (s0_we_o),
    .cyc_o       (s0_cyc_o),
    .stb_o       (s0_stb_o),
    .dat_i       (s0_dat_i),
    .ack_i       (s0_ack_i),
    .err_i       (s0_err_i)
  );

  wb_com_slave u_slave1 (
    .clk         (clk),
    .rst         (rst),
    .hdr_i       (s1_hdr),
    .hdr_empty_i (s1_hdr_empty),
    .wdat_i      (s1_wdat),
    .hdr_rden_o  (s1_hdr_rden),
    .wdat_rden_o (s1_wdat_rden),
    .rsp_o       (s1_rsp_in),
    .rsp_wren_o  (s1_rsp_wren),
    .rsp_full_i  (s1_rsp_full),
    .adr_o       (s1_adr_o),
    .dat_o       (s1_dat_o),
    .sel_o       (s1_sel_o),
    .we_o        (s1_we_o),
    .cyc_o       (s1_cyc_o),
    .stb_o       (s1_stb_o),
    .dat_i       (s1_dat_i),
    .ack_i       (s1_ack_i),
    .err_i       (s1_err_i)
  );

endmodule

/* src/wb_com_slave.sv */
// classic single cycles only, one transfer in flight; takes at least 3 clocks per transfer
`timescale 1ns/1ps
`include "wb_com_params.svh"

module wb_com_slave
  import wb_com_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  // request queue
  input  wb_req_hdr_t           hdr_i,
  input  logic                  hdr_empty_i,
  input  logic [`WB_COM_DW-1:0] wdat_i,
  output logic                  hdr_rden_o,
  output logic                  wdat_rden_o,
  // response queue
  output wb_rsp_t               rsp_o,
  output logic                  rsp_wren_o,
  input  logic                  rsp_full_i,
  // slave bus
  output logic [`WB_COM_AW-1:0] adr_o,
  output logic [`WB_COM_DW-1:0] dat_o,
  output logic [`WB_COM_SW-1:0] sel_o,
  output logic                  we_o,
  output logic                  cyc_o,
  output logic                  stb_o,
  input  logic [`WB_COM_DW-1:0] dat_i,
  input  logic                  ack_i,
  input  logic                  err_i
);

  wb_slv_state_e         state;
  wb_req_hdr_t           req_q;
  logic [`WB_COM_DW-1:0] wdat_q;
  wb_rsp_t               rsp_q;
  logic                  start;
  logic                  done;

  // only start when the response has somewhere to go
  assign start = (state == SLV_IDLE) && !hdr_empty_i && !rsp_full_i;
  assign done  = (state == SLV_CYCLE) && (ack_i || err_i);

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SLV_IDLE;
    end else begin
      case (state)
        SLV_IDLE: begin
          if (start) begin
            state <= SLV_CYCLE;
          end
        end
        SLV_CYCLE: begin
          if (done) begin
            state <= SLV_PUSH;
          end
        end
        default: state <= SLV_IDLE;
      endcase
    end
  end

  // popped request and captured response
  always_ff @(posedge clk) begin
    if (start) begin
      req_q <= hdr_i;
      if (hdr_i.we) begin
        wdat_q <= wdat_i;
      end
    end
    if (done) begin
      // writes return zero data
      rsp_q <= '{err: err_i, data: req_q.we ? {`WB_COM_DW{1'b0}} : dat_i};
    end
  end

  assign hdr_rden_o  = start;
  assign wdat_rden_o = start && hdr_i.we;
  assign rsp_o       = rsp_q;
  assign rsp_wren_o  = (state == SLV_PUSH);

  // --------------------
  // slave bus
  // --------------------
  assign adr_o = req_q.addr;
  assign sel_o = req_q.sel;
  assign we_o  = req_q.we;
  assign dat_o = wdat_q;
  assign cyc_o = (state == SLV_CYCLE);
  assign stb_o = (state == SLV_CYCLE);

  // classic cycle holds strobe and address until the slave answers
  a_stb_hold: assert property (@(posedge clk) disable iff (rst)
    stb_o && !(ack_i || err_i) |=> stb_o && cyc_o && $stable(adr_o))
    else $error("strobe dropped before ack or err");

endmodule

/* src/wb_com_master.sv */
// single pipelined master only; responses return in request order, unmapped addresses get err
`timescale 1ns/1ps
`include "wb_com_params.svh"

module wb_com_master
  import wb_com_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  // master bus
  input  logic [`WB_COM_AW-1:0] m_addr_i,
  input  logic [`WB_COM_DW-1:0] m_dat_i,
  input  logic [`WB_COM_SW-1:0] m_sel_i,
  input  logic                  m_cyc_i,
  input  logic                  m_stb_i,
  input  logic                  m_we_i,
  output logic [`WB_COM_DW-1:0] m_dat_o,
  output logic                  m_stall_o,
  output logic                  m_ack_o,
  output logic                  m_err_o,
  // slave 0 queues
  output wb_req_hdr_t           s0_hdr_o,
  input  logic                  s0_hdr_rden_i,
  output logic                  s0_hdr_empty_o,
  output logic [`WB_COM_DW-1:0] s0_wdat_o,
  input  logic                  s0_wdat_rden_i,
  input  wb_rsp_t               s0_rsp_i,
  input  logic                  s0_rsp_empty_i,
  output logic                  s0_rsp_rden_o,
  // slave 1 queues
  output wb_req_hdr_t           s1_hdr_o,
  input  logic                  s1_hdr_rden_i,
  output logic                  s1_hdr_empty_o,
  output logic [`WB_COM_DW-1:0] s1_wdat_o,
  input  logic                  s1_wdat_rden_i,
  input  wb_rsp_t               s1_rsp_i,
  input  logic                  s1_rsp_empty_i,
  output logic                  s1_rsp_rden_o
);

  localparam int TRK_D  = `WB_COM_TRACK_DEPTH;
  localparam int TRK_AW = $clog2(TRK_D);
  localparam int TRK_CW = $clog2(TRK_D + 1);

  wb_target_e        req_tgt;
  wb_req_hdr_t       req_hdr;
  logic              accept;
  logic              s0_hdr_full;
  logic              s1_hdr_full;
  logic              s0_hdr_wren;
  logic              s1_hdr_wren;
  // order tracker with the oldest request in entry 0
  wb_target_e        trk_q [TRK_D];
  logic [TRK_CW-1:0] trk_cnt;
  logic [TRK_CW-1:0] trk_wr_idx;
  wb_target_e        head_tgt;
  wb_rsp_t           rsp_sel;
  logic              rsp_vld;
  logic              retire;

  // --------------------
  // request side
  // --------------------
  always_comb begin
    if (m_addr_i >= `WB_COM_S0_LO && m_addr_i <= `WB_COM_S0_HI) begin
      req_tgt = TGT_S0;
    end else if (m_addr_i >= `WB_COM_S1_LO && m_addr_i <= `WB_COM_S1_HI) begin
      req_tgt = TGT_S1;
    end else begin
      req_tgt = TGT_NONE;
    end
  end

  assign m_stall_o = (req_tgt == TGT_S0 && s0_hdr_full) ||
                     (req_tgt == TGT_S1 && s1_hdr_full) ||
                     (trk_cnt == TRK_CW'(TRK_D));
  assign accept      = m_cyc_i && m_stb_i && !m_stall_o;
  assign req_hdr     = '{addr: m_addr_i, sel: m_sel_i, we: m_we_i};
  assign s0_hdr_wren = accept && req_tgt == TGT_S0;
  assign s1_hdr_wren = accept && req_tgt == TGT_S1;

  // data FIFOs never hold more than their header FIFOs, so only header full matters
  wb_com_fifo #(.WIDTH($bits(wb_req_hdr_t)), .ASIZE(`WB_COM_FIFO_ASIZE)) u_s0_hdr_fifo (
    .clk       (clk),
    .rst       (rst),
    .wr_en_i   (s0_hdr_wren),
    .wr_data_i (req_hdr),
    .rd_en_i   (s0_hdr_rden_i),
    .rd_data_o (s0_hdr_o),
    .full_o    (s0_hdr_full),
    .empty_o   (s0_hdr_empty_o)
  );

  wb_com_fifo #(.WIDTH(`WB_COM_DW), .ASIZE(`WB_COM_FIFO_ASIZE)) u_s0_dat_fifo (
    .clk       (clk),
    .rst       (rst),
    .wr_en_i   (s0_hdr_wren && m_we_i),
    .wr_data_i (m_dat_i),
    .rd_en_i   (s0_wdat_rden_i),
    .rd_data_o (s0_wdat_o),
    .full_o    (),
    .empty_o   ()
  );

  wb_com_fifo #(.WIDTH($bits(wb_req_hdr_t)), .ASIZE(`WB_COM_FIFO_ASIZE)) u_s1_hdr_fifo (
    .clk       (clk),
    .rst       (rst),
    .wr_en_i   (s1_hdr_wren),
    .wr_data_i (req_hdr),
    .rd_en_i   (s1_hdr_rden_i),
    .rd_data_o (s1_hdr_o),
    .full_o    (s1_hdr_full),
    .empty_o   (s1_hdr_empty_o)
  );

  wb_com_fifo #(.WIDTH(`WB_COM_DW), .ASIZE(`WB_COM_FIFO_ASIZE)) u_s1_dat_fifo (
    .clk       (clk),
    .rst       (rst),
    .wr_en_i   (s1_hdr_wren && m_we_i),
    .wr_data_i (m_dat_i),
    .rd_en_i   (s1_wdat_rden_i),
    .rd_data_o (s1_wdat_o),
    .full_o    (),
    .empty_o   ()
  );

  // --------------------
  // order tracker
  // --------------------
  // a retire in the same cycle shifts the queue down by one
  assign trk_wr_idx = retire ? trk_cnt - 1'b1 : trk_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      trk_cnt <= '0;
      for (int i = 0; i < TRK_D; i++) begin
        trk_q[i] <= TGT_NONE;
      end
    end else begin
      case ({accept, retire})
        2'b10:   trk_cnt <= trk_cnt + 1'b1;
        2'b01:   trk_cnt <= trk_cnt - 1'b1;
        default: trk_cnt <= trk_cnt;
      endcase
      if (retire) begin
        for (int i = 0; i < TRK_D - 1; i++) begin
          trk_q[i] <= trk_q[i+1];
        end
        trk_q[TRK_D-1] <= TGT_NONE;
      end
      if (accept) begin
        trk_q[trk_wr_idx[TRK_AW-1:0]] <= req_tgt;
      end
    end
  end

  // --------------------
  // response return
  // --------------------
  assign head_tgt = trk_q[0];

  always_comb begin
    case (head_tgt)
      TGT_S0: begin
        rsp_sel = s0_rsp_i;
        rsp_vld = !s0_rsp_empty_i;
      end
      TGT_S1: begin
        rsp_sel = s1_rsp_i;
        rsp_vld = !s1_rsp_empty_i;
      end
      default: begin
        // unmapped address answered without any slave
        rsp_sel = '{err: 1'b1, data: '0};
        rsp_vld = 1'b1;
      end
    endcase
  end

  assign retire        = (trk_cnt != '0) && rsp_vld;
  assign m_ack_o       = retire && !rsp_sel.err;
  assign m_err_o       = retire && rsp_sel.err;
  assign m_dat_o       = rsp_sel.data;
  assign s0_rsp_rden_o = retire && head_tgt == TGT_S0;
  assign s1_rsp_rden_o = retire && head_tgt == TGT_S1;

endmodule

/* src/wb_com_fifo.sv */
// first-word-fall-through FIFO, no overflow or underflow guard; callers respect full and empty
`timescale 1ns/1ps

module wb_com_fifo #(
  parameter int WIDTH = 32,
  parameter int ASIZE = 2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] wr_data_i,
  input  logic             rd_en_i,
  output logic [WIDTH-1:0] rd_data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int DEPTH = 1 << ASIZE;

  logic [WIDTH-1:0] mem [DEPTH];
  // extra msb tells full from empty
  logic [ASIZE:0]   wr_ptr;
  logic [ASIZE:0]   rd_ptr;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_ptr[ASIZE-1:0]] <= wr_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // head word is visible without a read strobe
  assign rd_data_o = mem[rd_ptr[ASIZE-1:0]];
  assign empty_o   = (wr_ptr == rd_ptr);
  assign full_o    = (wr_ptr[ASIZE] != rd_ptr[ASIZE]) &&
                     (wr_ptr[ASIZE-1:0] == rd_ptr[ASIZE-1:0]);

  // --------------------
  // checks
  // --------------------
  a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(wr_en_i && full_o))
    else $error("fifo written while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(rd_en_i && empty_o))
    else $error("fifo read while empty");

endmodule

/* src/wb_com_pkg.sv */
// struct widths follow the params header; one master and two slaves only
`include "wb_com_params.svh"

package wb_com_pkg;

  // --------------------
  // queue payloads
  // --------------------

  // request header as stored in the per-slave header FIFO
  typedef struct packed {
    logic [`WB_COM_AW-1:0] addr;
    logic [`WB_COM_SW-1:0] sel;
    logic                  we;
  } wb_req_hdr_t;

  // response as stored in the per-slave response FIFO
  typedef struct packed {
    logic                  err;
    logic [`WB_COM_DW-1:0] data;
  } wb_rsp_t;

  // --------------------
  // enums
  // --------------------

  // where a request goes, TGT_NONE is an unmapped address
  typedef enum logic [1:0] {
    TGT_S0,
    TGT_S1,
    TGT_NONE
  } wb_target_e;

  typedef enum logic [1:0] {
    SLV_IDLE,
    SLV_CYCLE,
    SLV_PUSH
  } wb_slv_state_e;

endpackage

/* include/wb_com_params.svh */
// widths and windows are shared by all blocks; windows are word addresses and must not overlap
`ifndef WB_COM_PARAMS_SVH
`define WB_COM_PARAMS_SVH

// --------------------
// bus widths
// --------------------
`define WB_COM_AW 32
`define WB_COM_DW 32
`define WB_COM_SW (`WB_COM_DW / 8)

// --------------------
// queue sizes
// --------------------
// log2 of request and response FIFO depth
`define WB_COM_FIFO_ASIZE 2
// outstanding requests held by the order tracker, keep a power of two
`define WB_COM_TRACK_DEPTH 8

// --------------------
// address windows
// --------------------
`define WB_COM_S0_LO 32'h0000_0000
`define WB_COM_S0_HI 32'h0000_0003
`define WB_COM_S1_LO 32'h0000_0004
`define WB_COM_S1_HI 32'h0000_0007

`endif
